//--- src/uop_pkg.sv
package uop_pkg;

	localparam int WORD_W = 16;

	////////////////////////////////////////
	// microword encodings
	////////////////////////////////////////
	typedef enum logic [1:0] {
		K_CORE,
		K_FLAGS,
		K_BRANCH, // no branching here, acts as nop
		K_IMM
	} uop_kind_e;

	typedef enum logic [1:0] {ST_NONE, ST_POP, ST_PUSH, ST_SWAP} stack_op_e;

	typedef enum logic [3:0] {
		G_MISC       = 4'h0,
		G_ALU8       = 4'h4,
		G_ALU16      = 4'h5,
		G_LOADREG8   = 4'h8,
		G_LOADREG16  = 4'h9,
		G_STOREREG8  = 4'hA,
		G_STOREREG16 = 4'hB
	} core_group_e;

	typedef enum logic [3:0] {M_DUP = 4'h7, M_NOP = 4'hB} misc_op_e;

	typedef enum logic [1:0] {FO_ADD, FO_REMOVE, FO_TEST, FO_SETALU} flag_op_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h2,
		ALU_AND = 4'h4,
		ALU_OR  = 4'h5,
		ALU_XOR = 4'h6,
		ALU_SHL = 4'h7,
		ALU_SHR = 4'h8,
		ALU_SAR = 4'h9,
		ALU_ROL = 4'hA,
		ALU_ROR = 4'hB,
		ALU_RCL = 4'hC,
		ALU_RCR = 4'hD
	} alu_op_e;

	typedef struct packed {
		uop_kind_e  kind;
		stack_op_e  stack_op;
		logic [1:0] sub;
		logic [3:0] group;
		logic [3:0] modifier;
		logic [3:0] sel;
	} uop_t; // low 16 bits double as loadimm data

	typedef struct packed {
		logic o;
		logic s;
		logic z;
		logic a;
		logic p;
		logic c;
	} alu_flags_t;

	typedef struct packed {
		stack_op_e         op;
		logic              load_top;
		logic [WORD_W-1:0] top_data;
	} stack_cmd_t;

	localparam int F_C = 0;
	localparam int F_P = 2;
	localparam int F_A = 4;
	localparam int F_Z = 6;
	localparam int F_S = 7;
	localparam int F_O = 11;

	localparam logic [3:0] REG_CS    = 4'd9;
	localparam logic [3:0] REG_FLAGS = 4'd14;

	localparam logic [WORD_W-1:0] FLAGS_RESET = 16'hF002;
	localparam logic [WORD_W-1:0] CS_RESET    = 16'hFFFF;

endpackage

//--- src/operand_stack.sv
`timescale 1ns/1ps

module operand_stack #(
	parameter int STACK_DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       reset_n,
	input  uop_pkg::stack_cmd_t        cmd,
	output logic [uop_pkg::WORD_W-1:0] e_top,
	output logic [uop_pkg::WORD_W-1:0] e_next,
	output logic [uop_pkg::WORD_W-1:0] e_bottom
);
	import uop_pkg::*;

	logic [WORD_W-1:0] ent [STACK_DEPTH]; // entry 0 is the top
	logic [WORD_W-1:0] moved [STACK_DEPTH];

	always_comb
	begin
		moved = ent;
		case (cmd.op)
			ST_POP: // rotate down, old top wraps to bottom
				for (int i = 0; i < STACK_DEPTH; i++)
					moved[i] = ent[(i + 1) % STACK_DEPTH];
			ST_PUSH: // rotate up
				for (int i = 0; i < STACK_DEPTH; i++)
					moved[i] = ent[(i + STACK_DEPTH - 1) % STACK_DEPTH];
			ST_SWAP:
			begin
				moved[0] = ent[1];
				moved[1] = ent[0];
			end
			default: ;
		endcase
		if (cmd.load_top)
			moved[0] = cmd.top_data; // load wins over the move
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			ent <= '{default: '0};
		else
			ent <= moved;
	end

	assign e_top = ent[0];
	assign e_next = ent[1];
	assign e_bottom = ent[STACK_DEPTH-1];

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic [3:0]                 rd_sel,
	input  logic                       rd_byte,
	input  logic                       wr_en,
	input  logic [3:0]                 wr_sel,
	input  logic                       wr_byte,
	input  logic [uop_pkg::WORD_W-1:0] wr_data,
	output logic [uop_pkg::WORD_W-1:0] rd_data,
	output logic [uop_pkg::WORD_W-1:0] flags
);
	import uop_pkg::*;

	// ax cx dx bx sp bp si di es cs ss ds fs gs flags ip
	logic [WORD_W-1:0] regs [16];
	logic [WORD_W-1:0] rd_word;

	////////////////////////////////////////
	// read side
	////////////////////////////////////////
	assign rd_word = regs[{2'b00, rd_sel[1:0]}]; // ax..bx for byte access

	always_comb
	begin
		if (!rd_byte)
			rd_data = regs[rd_sel];
		else if (rd_sel[2])
			rd_data = {8'h00, rd_word[15:8]}; // ah ch dh bh
		else
			rd_data = {8'h00, rd_word[7:0]};
	end

	assign flags = regs[REG_FLAGS];

	////////////////////////////////////////
	// write side
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			regs[REG_CS] <= CS_RESET;
			regs[REG_FLAGS] <= FLAGS_RESET;
		end
		else if (wr_en)
		begin
			if (!wr_byte)
				regs[wr_sel] <= wr_data;
			else if (wr_sel[2])
				regs[{2'b00, wr_sel[1:0]}][15:8] <= wr_data[7:0];
			else
				regs[{2'b00, wr_sel[1:0]}][7:0] <= wr_data[7:0];
		end
	end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu #(
	parameter int WIDTH = 16
) (
	input  logic [WIDTH-1:0]   a,
	input  logic [WIDTH-1:0]   b,
	input  uop_pkg::alu_op_e   op,
	input  logic               carry_in,
	output logic [WIDTH-1:0]   result,
	output uop_pkg::alu_flags_t flags_out
);
	import uop_pkg::*;

	localparam int MSB = WIDTH - 1;

	logic [WIDTH:0] res; // top bit is carry out
	logic ovf;

	always_comb
	begin
		case (op)
			ALU_ADD: res = {1'b0, a} + {1'b0, b};
			ALU_SUB: res = {1'b0, a} - {1'b0, b};
			ALU_AND: res = {1'b0, a & b};
			ALU_OR:  res = {1'b0, a | b};
			ALU_XOR: res = {1'b0, a ^ b};
			ALU_SHL: res = {a, 1'b0};
			ALU_SHR: res = {a[0], 1'b0, a[MSB:1]};
			ALU_SAR: res = {a[0], a[MSB], a[MSB:1]};
			ALU_ROL: res = {a, a[MSB]};
			ALU_ROR: res = {a[0], a[0], a[MSB:1]};
			ALU_RCL: res = {a, carry_in};
			ALU_RCR: res = {a[0], carry_in, a[MSB:1]};
			default: res = '0;
		endcase

		case (op)
			ALU_ADD: ovf = (res[MSB] ^ a[MSB]) & (res[MSB] ^ b[MSB]);
			ALU_SUB: ovf = (res[MSB] ^ a[MSB]) & (a[MSB] ^ b[MSB]);
			ALU_SHL, ALU_ROL, ALU_RCL: ovf = a[MSB] ^ a[MSB-1];
			ALU_SHR: ovf = a[MSB];
			ALU_ROR, ALU_RCR: ovf = res[MSB] ^ res[MSB-1];
			default: ovf = 1'b0; // logic ops and sar
		endcase
	end

	assign result = res[MSB:0];

	assign flags_out.o = ovf;
	assign flags_out.s = res[MSB];
	assign flags_out.z = ~|res[MSB:0];
	assign flags_out.a = res[4] ^ a[4] ^ b[4];
	assign flags_out.p = ~^res[7:0]; // low byte only, even parity
	assign flags_out.c = res[WIDTH];

endmodule

//--- src/uop_control.sv
`timescale 1ns/1ps

module uop_control (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       uop_valid,
	input  uop_pkg::uop_t              uop,
	input  logic [uop_pkg::WORD_W-1:0] e_top,
	input  logic [uop_pkg::WORD_W-1:0] e_next,
	input  logic [uop_pkg::WORD_W-1:0] rd_data,
	input  logic [uop_pkg::WORD_W-1:0] flags,
	input  logic [7:0]                 alu8_res,
	input  uop_pkg::alu_flags_t        alu8_flags,
	input  logic [15:0]                alu16_res,
	input  uop_pkg::alu_flags_t        alu16_flags,
	output uop_pkg::stack_cmd_t        stack_cmd,
	output uop_pkg::alu_op_e           alu_op,
	output logic [3:0]                 rd_sel,
	output logic                       rd_byte,
	output logic                       wr_en,
	output logic [3:0]                 wr_sel,
	output logic                       wr_byte,
	output logic [uop_pkg::WORD_W-1:0] wr_data,
	output logic                       done
);
	import uop_pkg::*;

	typedef enum logic {PH_IDLE, PH_EXECUTE} phase_e;
	typedef enum logic [1:0] {EX_ALU8, EX_ALU16, EX_DUP, EX_TEST} exec_e;

	phase_e phase;
	exec_e ex_op;
	exec_e ex_dec;
	logic [11:0] ex_mask;
	alu_flags_t alu_flags_q;

	logic accept;
	logic is_exec;
	logic [11:0] mask;
	core_group_e group;
	flag_op_e fop;
	logic [WORD_W-1:0] ex_result;
	logic [WORD_W-1:0] alu_merged;

	assign accept = uop_valid && (phase == PH_IDLE) && !done;
	assign mask = {uop.group, uop.modifier, uop.sel};
	assign group = core_group_e'(uop.group);
	assign fop = flag_op_e'(uop.sub);

	assign rd_sel = uop.sel;
	assign rd_byte = (group == G_LOADREG8);

	always_comb
	begin
		alu_merged = flags;
		alu_merged[F_C] = mask[F_C] ? alu_flags_q.c : flags[F_C];
		alu_merged[F_P] = mask[F_P] ? alu_flags_q.p : flags[F_P];
		alu_merged[F_A] = mask[F_A] ? alu_flags_q.a : flags[F_A];
		alu_merged[F_Z] = mask[F_Z] ? alu_flags_q.z : flags[F_Z];
		alu_merged[F_S] = mask[F_S] ? alu_flags_q.s : flags[F_S];
		alu_merged[F_O] = mask[F_O] ? alu_flags_q.o : flags[F_O];
	end

	always_comb
	begin
		case (ex_op)
			EX_ALU8:  ex_result = {8'h00, alu8_res};
			EX_ALU16: ex_result = alu16_res;
			EX_DUP:   ex_result = e_next;
			default:  ex_result = flags & {4'h0, ex_mask};
		endcase
	end

	////////////////////////////////////////
	// decode
	////////////////////////////////////////
	always_comb
	begin
		is_exec = 1'b0;
		ex_dec = EX_DUP;
		stack_cmd.op = ST_NONE;
		stack_cmd.load_top = 1'b0;
		stack_cmd.top_data = rd_data;
		wr_en = 1'b0;
		wr_sel = uop.sel;
		wr_byte = 1'b0;
		wr_data = e_top;
		if (phase == PH_EXECUTE)
		begin
			stack_cmd.load_top = 1'b1; // second edge, result to top
			stack_cmd.top_data = ex_result;
		end
		else if (accept)
		begin
			case (uop.kind)
				K_IMM:
				begin
					stack_cmd.op = ST_PUSH;
					stack_cmd.load_top = 1'b1;
					stack_cmd.top_data = uop[15:0];
				end
				K_CORE:
				begin
					stack_cmd.op = uop.stack_op;
					case (group)
						G_ALU8, G_ALU16:
						begin
							is_exec = 1'b1;
							ex_dec = (group == G_ALU8) ? EX_ALU8 : EX_ALU16;
						end
						G_MISC:
							is_exec = (misc_op_e'(uop.sel) == M_DUP);
						G_LOADREG8, G_LOADREG16:
							stack_cmd.load_top = 1'b1;
						G_STOREREG8, G_STOREREG16:
						begin
							wr_en = 1'b1;
							wr_byte = (group == G_STOREREG8);
						end
						default: ;
					endcase
				end
				K_FLAGS:
				begin
					stack_cmd.op = uop.stack_op;
					wr_sel = REG_FLAGS;
					wr_en = (fop != FO_TEST);
					is_exec = (fop == FO_TEST);
					ex_dec = EX_TEST;
					case (fop)
						FO_ADD:    wr_data = flags | {4'h0, mask};
						FO_REMOVE: wr_data = flags & ~{4'h0, mask};
						default:   wr_data = alu_merged;
					endcase
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// phase and done
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			phase <= PH_IDLE;
			done <= 1'b0;
			ex_op <= EX_DUP;
			alu_flags_q <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (phase == PH_EXECUTE)
			begin
				phase <= PH_IDLE;
				done <= 1'b1;
				if (ex_op == EX_ALU8)
					alu_flags_q <= alu8_flags;
				else if (ex_op == EX_ALU16)
					alu_flags_q <= alu16_flags;
			end
			else if (accept)
			begin
				if (is_exec)
				begin
					phase <= PH_EXECUTE;
					ex_op <= ex_dec;
				end
				else
					done <= 1'b1; // fetch-phase op already finished
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			alu_op <= alu_op_e'(uop.sel);
			ex_mask <= mask; // testflags mask for the second edge
		end
	end

endmodule

//--- src/uop_core.sv
`timescale 1ns/1ps

module uop_core #(
	parameter int STACK_DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       uop_valid,
	input  uop_pkg::uop_t              uop,
	output logic                       done,
	output logic [uop_pkg::WORD_W-1:0] tos,
	output logic [uop_pkg::WORD_W-1:0] flags
);
	import uop_pkg::*;

	stack_cmd_t stack_cmd;
	alu_op_e alu_op;
	logic [WORD_W-1:0] e_top;
	logic [WORD_W-1:0] e_next;
	logic [WORD_W-1:0] e_bottom;
	logic [3:0] rd_sel;
	logic [3:0] wr_sel;
	logic rd_byte;
	logic wr_en;
	logic wr_byte;
	logic [WORD_W-1:0] rd_data;
	logic [WORD_W-1:0] wr_data;
	logic [7:0] alu8_res;
	logic [15:0] alu16_res;
	alu_flags_t alu8_flags;
	alu_flags_t alu16_flags;

	assign tos = e_top;

	uop_control ctrl_i (.*);

	operand_stack #(
		.STACK_DEPTH(STACK_DEPTH)
	) stack_i (
		.cmd(stack_cmd),
		.*
	);

	reg_file regs_i (.*);

	////////////////////////////////////////
	// both ALUs see bottom op top
	////////////////////////////////////////
	alu #(
		.WIDTH(8)
	) alu8_i (
		.a(e_bottom[7:0]),
		.b(e_top[7:0]),
		.op(alu_op),
		.carry_in(flags[F_C]),
		.result(alu8_res),
		.flags_out(alu8_flags)
	);

	alu #(
		.WIDTH(16)
	) alu16_i (
		.a(e_bottom),
		.b(e_top),
		.op(alu_op),
		.carry_in(flags[F_C]),
		.result(alu16_res),
		.flags_out(alu16_flags)
	);

endmodule

//--- tb/uop_core_checker.sv
`timescale 1ns/1ps

module uop_core_checker (
	input logic clk,
	input logic reset_n,
	input logic uop_valid,
	input logic done
);

	////////////////////////////////////////
	// done pulse timing
	////////////////////////////////////////
	a_done_single: assert property (@(posedge clk) disable iff (!reset_n)
		done |=> !done)
	else $error("done stayed high for two cycles");

	// a strobe seen with done low is answered at one or two edges later
	a_done_latency: assert property (@(posedge clk) disable iff (!reset_n)
		$past(uop_valid && !done, 2) |-> (done || $past(done)))
	else $error("strobe got no done pulse within two cycles");

	a_reset_done: assert property (@(posedge clk)
		!reset_n |=> !done)
	else $error("done high in the cycle after reset");

endmodule

bind uop_core uop_core_checker chk_i (
	.clk(clk),
	.reset_n(reset_n),
	.uop_valid(uop_valid),
	.done(done)
);

//--- tb/uop_core_tb.sv
`timescale 1ns/1ps

module uop_core_tb;
	import uop_pkg::*;

	logic clk;
	logic reset_n;
	logic uop_valid;
	uop_t uop;
	logic done;
	logic [15:0] tos;
	logic [15:0] flags;

	// reference model state
	logic [15:0] m_st [4]; // entry 0 is the top
	logic [15:0] m_regs [16];
	alu_flags_t m_held;

	int errors;
	int checks;
	alu_op_e ops [12];

	uop_core #(
		.STACK_DEPTH(4)
	) dut (
		.clk(clk),
		.reset_n(reset_n),
		.uop_valid(uop_valid),
		.uop(uop),
		.done(done),
		.tos(tos),
		.flags(flags)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////
	// microword builders
	////////////////////////////////////////
	function automatic uop_t imm_uop(input logic [15:0] v);
		uop_t u;
		u = '0;
		u.kind = K_IMM;
		u[15:0] = v;
		return u;
	endfunction

	function automatic uop_t core_uop(input stack_op_e op, input core_group_e g,
		input logic [3:0] sel);
		uop_t u;
		u = '0;
		u.kind = K_CORE;
		u.stack_op = op;
		u.group = g;
		u.sel = sel;
		return u;
	endfunction

	function automatic uop_t flags_uop(input stack_op_e op, input flag_op_e f,
		input logic [11:0] mask);
		uop_t u;
		u = '0;
		u.kind = K_FLAGS;
		u.stack_op = op;
		u.sub = f;
		{u.group, u.modifier, u.sel} = mask;
		return u;
	endfunction

	////////////////////////////////////////
	// model
	////////////////////////////////////////
	task automatic move_stack(input stack_op_e op);
		logic [15:0] old [4];
		old = m_st;
		case (op)
			ST_POP:  m_st = '{old[1], old[2], old[3], old[0]};
			ST_PUSH: m_st = '{old[3], old[0], old[1], old[2]};
			ST_SWAP:
			begin
				m_st[0] = old[1];
				m_st[1] = old[0];
			end
			default: ;
		endcase
	endtask

	// x86 style single bit shifts for w of 8 or 16
	task automatic alu_model(input int w, input alu_op_e op, input logic [15:0] a_in,
		input logic [15:0] b_in, input logic cin, output logic [15:0] r,
		output alu_flags_t f);
		logic [15:0] m;
		logic [15:0] a;
		logic [15:0] b;
		logic am;
		logic bm;
		int msb;
		int s;
		msb = w - 1;
		m = (w == 8) ? 16'h00ff : 16'hffff;
		a = a_in & m;
		b = b_in & m;
		am = a[msb];
		bm = b[msb];
		f = '0;
		case (op)
			ALU_ADD:
			begin
				s = int'(a) + int'(b);
				r = 16'(s) & m;
				f.c = s > int'(m);
				f.o = (am == bm) && (r[msb] != am);
			end
			ALU_SUB:
			begin
				r = (a - b) & m;
				f.c = a < b; // borrow
				f.o = (am != bm) && (r[msb] != am);
			end
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SHL:
			begin
				r = (a << 1) & m;
				f.c = am;
				f.o = r[msb] ^ f.c;
			end
			ALU_SHR:
			begin
				r = a >> 1;
				f.c = a[0];
				f.o = am;
			end
			ALU_SAR:
			begin
				r = (a >> 1) | (16'(am) << msb);
				f.c = a[0];
			end
			ALU_ROL:
			begin
				r = ((a << 1) | 16'(am)) & m;
				f.c = am;
				f.o = r[msb] ^ f.c;
			end
			ALU_ROR:
			begin
				r = (a >> 1) | (16'(a[0]) << msb);
				f.c = a[0];
				f.o = r[msb] ^ r[msb-1];
			end
			ALU_RCL:
			begin
				r = ((a << 1) | 16'(cin)) & m;
				f.c = am;
				f.o = r[msb] ^ f.c;
			end
			default: // rcr
			begin
				r = (a >> 1) | (16'(cin) << msb);
				f.c = a[0];
				f.o = r[msb] ^ r[msb-1];
			end
		endcase
		f.z = (r == 16'h0000);
		f.s = r[msb];
		f.a = r[4] ^ a[4] ^ b[4];
		f.p = ~^r[7:0];
	endtask

	function automatic logic [15:0] merge_alu_flags(input logic [15:0] f, input alu_flags_t h,
		input logic [11:0] mask);
		logic [15:0] r;
		r = f;
		if (mask[F_C]) r[F_C] = h.c;
		if (mask[F_P]) r[F_P] = h.p;
		if (mask[F_A]) r[F_A] = h.a;
		if (mask[F_Z]) r[F_Z] = h.z;
		if (mask[F_S]) r[F_S] = h.s;
		if (mask[F_O]) r[F_O] = h.o;
		return r;
	endfunction

	////////////////////////////////////////
	// checks and handshake
	////////////////////////////////////////
	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic issue(input uop_t u, input int lat, input logic [15:0] exp_tos,
		input string what);
		int cycles;
		uop = u;
		uop_valid = 1'b1;
		@(negedge clk);
		uop_valid = 1'b0;
		cycles = 1;
		while (!done && cycles < 8)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!done)
		begin
			$display("ERROR: no done pulse within %0d cycles after %s", cycles, what);
			$display("*** FAILED ***");
			$finish;
		end
		else
		begin
			check_word({what, " done latency"}, 16'(cycles), 16'(lat));
			check_word({what, " tos"}, tos, exp_tos);
			check_word({what, " flags"}, flags, m_regs[REG_FLAGS]);
			@(negedge clk); // let done drop
		end
	endtask

	task automatic end_test(input string name, input int base_checks, input int base_errors);
		$display("test %s: %0d checks, %0d errors", name, checks - base_checks,
			errors - base_errors);
	endtask

	task automatic push_imm(input logic [15:0] v);
		move_stack(ST_PUSH);
		m_st[0] = v;
		issue(imm_uop(v), 1, m_st[0], "loadimm");
	endtask

	// one ALU pass where w selects alu8 or alu16
	task automatic run_alu(input int w);
		logic [15:0] r;
		alu_flags_t hf;
		for (int j = 0; j < 12; j++)
		begin
			push_imm(16'($urandom));
			push_imm(16'($urandom));
			if (w == 8)
			begin
				if ($urandom_range(0, 1) == 1)
				begin
					m_regs[REG_FLAGS][F_C] = 1'b1;
					issue(flags_uop(ST_NONE, FO_ADD, 12'h001), 1, m_st[0], "addflags");
				end
				else
				begin
					m_regs[REG_FLAGS][F_C] = 1'b0;
					issue(flags_uop(ST_NONE, FO_REMOVE, 12'h001), 1, m_st[0], "removeflags");
				end
			end
			move_stack(ST_POP);
			alu_model(w, ops[j], m_st[3], m_st[0], m_regs[REG_FLAGS][F_C], r, hf);
			m_st[0] = r;
			m_held = hf;
			issue(core_uop(ST_POP, (w == 8) ? G_ALU8 : G_ALU16, ops[j]), 2, m_st[0],
				(w == 8) ? "alu8" : "alu16");
			m_regs[REG_FLAGS] = merge_alu_flags(m_regs[REG_FLAGS], m_held, 12'hFFF);
			issue(flags_uop(ST_NONE, FO_SETALU, 12'hFFF), 1, m_st[0], "setaluflags");
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial
	begin
		stack_op_e sop;
		logic [11:0] mask;
		int idx;
		int k;
		int bc;
		int be;
		errors = 0;
		checks = 0;
		reset_n = 1'b0;
		uop_valid = 1'b0;
		uop = '0;
		void'($urandom(2));
		ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL,
			ALU_SHR, ALU_SAR, ALU_ROL, ALU_ROR, ALU_RCL, ALU_RCR};
		for (int i = 0; i < 16; i++)
			m_regs[i] = '0;
		m_regs[REG_CS] = 16'hFFFF;
		m_regs[REG_FLAGS] = 16'hF002;
		m_st = '{default: '0};
		m_held = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		bc = checks;
		be = errors;
		check_word("done", 16'(done), 16'h0000);
		check_word("tos", tos, 16'h0000);
		check_word("flags", flags, 16'hF002);
		end_test("reset", bc, be);
		@(negedge clk);

		bc = checks;
		be = errors;
		for (int i = 0; i < 4; i++)
			push_imm(16'($urandom));
		for (int i = 0; i < 32; i++)
		begin
			k = $urandom_range(0, 3);
			if (k == 0)
			begin
				move_stack(ST_PUSH);
				m_st[0] = m_st[1];
				issue(core_uop(ST_PUSH, G_MISC, M_DUP), 2, m_st[0], "dup");
			end
			else
			begin
				sop = stack_op_e'(k);
				move_stack(sop);
				issue(core_uop(sop, G_MISC, M_NOP), 1, m_st[0], "nop");
			end
		end
		end_test("stack_moves", bc, be);

		bc = checks;
		be = errors;
		run_alu(16);
		end_test("alu16", bc, be);

		bc = checks;
		be = errors;
		run_alu(8);
		end_test("alu8", bc, be);

		bc = checks;
		be = errors;
		for (int i = 0; i < 32; i++)
		begin
			push_imm(16'($urandom));
			idx = $urandom_range(0, 15);
			if ($urandom_range(0, 1) == 1)
			begin
				m_regs[idx] = m_st[0];
				issue(core_uop(ST_NONE, G_STOREREG16, 4'(idx)), 1, m_st[0], "storereg16");
			end
			else
			begin
				idx = idx % 8;
				if (idx >= 4)
					m_regs[idx-4][15:8] = m_st[0][7:0]; // ah..bh alias
				else
					m_regs[idx][7:0] = m_st[0][7:0];
				issue(core_uop(ST_NONE, G_STOREREG8, 4'(idx)), 1, m_st[0], "storereg8");
			end
			if ($urandom_range(0, 1) == 1)
				idx = $urandom_range(0, 15);
			move_stack(ST_PUSH);
			if ($urandom_range(0, 1) == 1)
			begin
				m_st[0] = m_regs[idx];
				issue(core_uop(ST_PUSH, G_LOADREG16, 4'(idx)), 1, m_st[0], "loadreg16");
			end
			else
			begin
				idx = idx % 8;
				m_st[0] = (idx >= 4) ? {8'h00, m_regs[idx-4][15:8]} : {8'h00, m_regs[idx][7:0]};
				issue(core_uop(ST_PUSH, G_LOADREG8, 4'(idx)), 1, m_st[0], "loadreg8");
			end
		end
		end_test("registers", bc, be);

		bc = checks;
		be = errors;
		for (int i = 0; i < 32; i++)
		begin
			mask = 12'($urandom);
			k = $urandom_range(0, 2);
			if (k == 0)
			begin
				m_regs[REG_FLAGS] = m_regs[REG_FLAGS] | {4'h0, mask};
				issue(flags_uop(ST_NONE, FO_ADD, mask), 1, m_st[0], "addflags");
			end
			else if (k == 1)
			begin
				m_regs[REG_FLAGS] = m_regs[REG_FLAGS] & ~{4'h0, mask};
				issue(flags_uop(ST_NONE, FO_REMOVE, mask), 1, m_st[0], "removeflags");
			end
			else
			begin
				move_stack(ST_PUSH);
				m_st[0] = m_regs[REG_FLAGS] & {4'h0, mask};
				issue(flags_uop(ST_PUSH, FO_TEST, mask), 2, m_st[0], "testflags");
			end
		end
		end_test("flag_ops", bc, be);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- uop_core.f
src/uop_pkg.sv
src/operand_stack.sv
src/reg_file.sv
src/alu.sv
src/uop_control.sv
src/uop_core.sv
tb/uop_core_checker.sv
tb/uop_core_tb.sv

//--- Makefile
TOP = uop_core_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f uop_core.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
